// File: verilog/c2c_pkg.sv
//----------------------------------------
// Shared widths, frame layout and types of the card-to-card write bridge
// Header beat carries the opcode in bits 63 to 56 and the address in 31 to 0
// Data beat carries the strobe in bits 35 to 32 and the data in 31 to 0
// Unused frame bits are sent as zero and ignored on receive
// Single-beat writes only, no IDs and no bursts
//----------------------------------------
package c2c_pkg;

	// AXI side
	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8;

	// Aurora side
	localparam int lane_count   = 4;
	localparam int stream_width = 64;

	// Frame field positions
	localparam int opcode_msb = 63;
	localparam int opcode_lsb = 56;
	localparam int strb_lsb   = 32;

	typedef enum logic [7:0] {
		op_write = 8'h57,
		op_nop   = 8'h4e
	} c2c_opcode_t;

	typedef enum logic [1:0] {
		st_down,
		st_settle,
		st_up
	} link_state_t;

	// One received write, as queued
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] data;
		logic [strb_width-1:0] strb;
	} cmd_t;

	localparam int link_settle_cycles = 16;
	localparam int cmd_fifo_depth     = 4;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: verilog/link_ctrl.sv
//----------------------------------------
// Link qualifier for the Aurora status lines
// Needs link_settle_cycles good cycles in a row before link_up
// Any bad cycle drops link_up on the next clock
//----------------------------------------
`timescale 1ns/100ps

module link_ctrl (
	input  logic                           aurora_clk,
	input  logic                           rst,
	input  logic                           hard_err,
	input  logic                           ch_up,
	input  logic [c2c_pkg::lane_count-1:0] lane_up,
	output logic                           link_up
);
	import c2c_pkg::*;

	typedef logic [$clog2(link_settle_cycles)-1:0] settle_cnt_t;

	link_state_t state;
	settle_cnt_t settle_cnt;
	logic        status_ok;

	// Channel up, all lanes up and no hard error
	assign status_ok = ch_up && (&lane_up) && !hard_err;

	always_ff @(posedge aurora_clk) begin
		if (rst) begin
			state      <= st_down;
			settle_cnt <= '0;
			link_up    <= 1'b0;
		end else begin
			link_up <= (state == st_up) && status_ok;
			if (!status_ok) begin
				state      <= st_down;
				settle_cnt <= '0;
			end else begin
				case (state)
					st_down: begin
						state      <= st_settle;
						settle_cnt <= settle_cnt_t'(1);
					end
					st_settle: begin
						// Count holds the good cycles seen before this one
						if (settle_cnt == settle_cnt_t'(link_settle_cycles - 1))
							state <= st_up;
						else
							settle_cnt <= settle_cnt + settle_cnt_t'(1);
					end
					st_up: state <= st_up;
					default: state <= st_down;
				endcase
			end
		end
	end

endmodule

// File: verilog/tx_framer.sv
//----------------------------------------
// Slave write to TX frame converter
// AW and W are accepted together, one write in flight
// Link down at acceptance gives SLVERR and sends nothing
// TX back-pressure can stall the framer without limit
//----------------------------------------
`timescale 1ns/100ps

module tx_framer (
	input  logic                             aurora_clk,
	input  logic                             rst,
	input  logic                             link_up,
	input  logic [c2c_pkg::addr_width-1:0]   s_awaddr,
	input  logic                             s_awvalid,
	output logic                             s_awready,
	input  logic [c2c_pkg::data_width-1:0]   s_wdata,
	input  logic [c2c_pkg::strb_width-1:0]   s_wstrb,
	input  logic                             s_wvalid,
	output logic                             s_wready,
	output logic [1:0]                       s_bresp,
	output logic                             s_bvalid,
	input  logic                             s_bready,
	output logic [c2c_pkg::stream_width-1:0] tx_tdata,
	output logic                             tx_tlast,
	output logic                             tx_tvalid,
	input  logic                             tx_tready
);
	import c2c_pkg::*;

	typedef enum logic [1:0] {
		fr_idle,
		fr_hdr,
		fr_data,
		fr_resp
	} fr_state_t;

	fr_state_t             state;
	logic [addr_width-1:0] addr_q;
	logic [data_width-1:0] data_q;
	logic [strb_width-1:0] strb_q;
	logic                  accept;

	// Both channels taken in the same cycle
	assign accept    = (state == fr_idle) && s_awvalid && s_wvalid;
	assign s_awready = accept;
	assign s_wready  = accept;

	assign tx_tvalid = (state == fr_hdr) || (state == fr_data);
	assign tx_tlast  = (state == fr_data);
	assign s_bvalid  = (state == fr_resp);

	// Beat builder
	always_comb begin
		tx_tdata = '0;
		if (state == fr_data) begin
			tx_tdata[strb_lsb +: strb_width] = strb_q;
			tx_tdata[data_width-1:0]         = data_q;
		end else begin
			tx_tdata[opcode_msb:opcode_lsb] = op_write;
			tx_tdata[addr_width-1:0]        = addr_q;
		end
	end

	always_ff @(posedge aurora_clk) begin
		if (rst) begin
			state   <= fr_idle;
			s_bresp <= resp_okay;
		end else begin
			case (state)
				fr_idle: begin
					if (accept) begin
						state   <= link_up ? fr_hdr : fr_resp;
						s_bresp <= link_up ? resp_okay : resp_slverr;
					end
				end
				fr_hdr:  if (tx_tready) state <= fr_data;
				fr_data: if (tx_tready) state <= fr_resp;
				fr_resp: if (s_bready) state <= fr_idle;
				default: state <= fr_idle;
			endcase
		end
	end

	// Write payload
	always_ff @(posedge aurora_clk) begin
		if (accept) begin
			addr_q <= s_awaddr;
			data_q <= s_wdata;
			strb_q <= s_wstrb;
		end
	end

endmodule

// File: verilog/rx_deframer.sv
//----------------------------------------
// RX frame parser feeding the command queue
// Beats are ignored while the link is down
// No back-pressure so a write seen with the queue full is lost
//----------------------------------------
`timescale 1ns/100ps

module rx_deframer (
	input  logic                             aurora_clk,
	input  logic                             rst,
	input  logic                             link_up,
	input  logic [c2c_pkg::stream_width-1:0] rx_tdata,
	input  logic                             rx_tlast,
	input  logic                             rx_tvalid,
	input  logic                             cmd_full,
	output logic                             cmd_push,
	output c2c_pkg::cmd_t                    cmd_data,
	output logic                             rx_overflow
);
	import c2c_pkg::*;

	typedef enum logic [1:0] {
		df_hdr,
		df_data,
		df_skip
	} df_state_t;

	df_state_t             state;
	c2c_opcode_t           opcode;
	logic [addr_width-1:0] addr_q;
	logic                  beat;
	logic                  cmd_done;

	assign beat     = rx_tvalid && link_up;
	assign opcode   = c2c_opcode_t'(rx_tdata[opcode_msb:opcode_lsb]);
	// Closing data beat of a write frame
	assign cmd_done = beat && (state == df_data) && rx_tlast;

	always_ff @(posedge aurora_clk) begin
		if (rst) begin
			state       <= df_hdr;
			cmd_push    <= 1'b0;
			rx_overflow <= 1'b0;
		end else begin
			cmd_push    <= cmd_done && !cmd_full;
			rx_overflow <= cmd_done && cmd_full;
			if (!link_up) begin
				state <= df_hdr;
			end else if (rx_tvalid) begin
				case (state)
					df_hdr: begin
						case (opcode)
							op_write: if (!rx_tlast) state <= df_data;
							// Nop and unknown opcodes have nothing to queue
							default:  if (!rx_tlast) state <= df_skip;
						endcase
					end
					df_data: state <= rx_tlast ? df_hdr : df_skip;
					df_skip: if (rx_tlast) state <= df_hdr;
					default: state <= df_hdr;
				endcase
			end
		end
	end

	// Address from the header and the rest from the data beat
	always_ff @(posedge aurora_clk) begin
		if (beat && (state == df_hdr))
			addr_q <= rx_tdata[addr_width-1:0];
		if (cmd_done) begin
			cmd_data.addr <= addr_q;
			cmd_data.data <= rx_tdata[data_width-1:0];
			cmd_data.strb <= rx_tdata[strb_lsb +: strb_width];
		end
	end

endmodule

// File: verilog/cmd_fifo.sv
//----------------------------------------
// Command queue, first-word-fall-through
// depth must be a power of two
// Push while full and pop while empty are ignored
//----------------------------------------
`timescale 1ns/100ps

module cmd_fifo #(
	parameter int depth = c2c_pkg::cmd_fifo_depth
) (
	input  logic          aurora_clk,
	input  logic          rst,
	input  logic          push,
	input  c2c_pkg::cmd_t push_data,
	output logic          full,
	input  logic          pop,
	output logic          empty,
	output c2c_pkg::cmd_t head
);
	import c2c_pkg::*;

	typedef logic [$clog2(depth)-1:0]   ptr_t;
	typedef logic [$clog2(depth+1)-1:0] count_t;

	cmd_t   mem [depth];
	ptr_t   wr_ptr;
	ptr_t   rd_ptr;
	count_t count;
	logic   do_push;
	logic   do_pop;

	assign full    = (count == count_t'(depth));
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge aurora_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap on their own width
			if (do_push)
				wr_ptr <= wr_ptr + ptr_t'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + ptr_t'(1);
			if (do_push && !do_pop)
				count <= count + count_t'(1);
			else if (do_pop && !do_push)
				count <= count - count_t'(1);
		end
	end

	always_ff @(posedge aurora_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

// File: verilog/axi_write_master.sv
//----------------------------------------
// Replays queued commands as single-beat AXI writes
// One write at a time, in queue order
// The B response code is not looked at
//----------------------------------------
`timescale 1ns/100ps

module axi_write_master (
	input  logic                           aurora_clk,
	input  logic                           rst,
	input  logic                           cmd_empty,
	input  c2c_pkg::cmd_t                  cmd_head,
	output logic                           cmd_pop,
	output logic [c2c_pkg::addr_width-1:0] m_awaddr,
	output logic                           m_awvalid,
	input  logic                           m_awready,
	output logic [c2c_pkg::data_width-1:0] m_wdata,
	output logic [c2c_pkg::strb_width-1:0] m_wstrb,
	output logic                           m_wvalid,
	input  logic                           m_wready,
	input  logic                           m_bvalid,
	output logic                           m_bready
);
	typedef enum logic [1:0] {
		wm_idle,
		wm_issue,
		wm_resp
	} wm_state_t;

	wm_state_t state;
	logic      aw_done;
	logic      w_done;

	assign cmd_pop = (state == wm_idle) && !cmd_empty;

	// Channel finished before or in this cycle
	assign aw_done = !m_awvalid || m_awready;
	assign w_done  = !m_wvalid || m_wready;

	always_ff @(posedge aurora_clk) begin
		if (rst) begin
			state     <= wm_idle;
			m_awvalid <= 1'b0;
			m_wvalid  <= 1'b0;
			m_bready  <= 1'b0;
		end else begin
			case (state)
				wm_idle: begin
					if (cmd_pop) begin
						state     <= wm_issue;
						m_awvalid <= 1'b1;
						m_wvalid  <= 1'b1;
					end
				end
				wm_issue: begin
					if (m_awready)
						m_awvalid <= 1'b0;
					if (m_wready)
						m_wvalid <= 1'b0;
					if (aw_done && w_done) begin
						state    <= wm_resp;
						m_bready <= 1'b1;
					end
				end
				wm_resp: begin
					if (m_bvalid) begin
						state    <= wm_idle;
						m_bready <= 1'b0;
					end
				end
				default: state <= wm_idle;
			endcase
		end
	end

	// Popped entry held for the whole write
	always_ff @(posedge aurora_clk) begin
		if (cmd_pop) begin
			m_awaddr <= cmd_head.addr;
			m_wdata  <= cmd_head.data;
			m_wstrb  <= cmd_head.strb;
		end
	end

endmodule

// File: verilog/c2c_top.sv
//----------------------------------------
// Card-to-card write bridge, everything on aurora_clk
// Slave writes go out as two-beat frames on the TX stream
// RX write frames are queued and replayed as master writes
// RX has no back-pressure, a full queue drops the frame
// The master B response code is not checked
//----------------------------------------
`timescale 1ns/100ps

module c2c_top (
	input  logic                               aurora_clk,
	input  logic                               rst,
	// Aurora status
	input  logic                               hard_err,
	input  logic                               ch_up,
	input  logic [c2c_pkg::lane_count-1:0]     lane_up,
	output logic                               link_up,
	// AXI slave write
	input  logic [c2c_pkg::addr_width-1:0]     s_awaddr,
	input  logic                               s_awvalid,
	output logic                               s_awready,
	input  logic [c2c_pkg::data_width-1:0]     s_wdata,
	input  logic [c2c_pkg::strb_width-1:0]     s_wstrb,
	input  logic                               s_wvalid,
	output logic                               s_wready,
	output logic [1:0]                         s_bresp,
	output logic                               s_bvalid,
	input  logic                               s_bready,
	// Aurora TX stream
	output logic [c2c_pkg::stream_width-1:0]   tx_tdata,
	output logic                               tx_tlast,
	output logic                               tx_tvalid,
	input  logic                               tx_tready,
	// Aurora RX stream
	input  logic [c2c_pkg::stream_width-1:0]   rx_tdata,
	input  logic                               rx_tlast,
	input  logic                               rx_tvalid,
	output logic                               rx_overflow,
	// AXI master write
	output logic [c2c_pkg::addr_width-1:0]     m_awaddr,
	output logic                               m_awvalid,
	input  logic                               m_awready,
	output logic [c2c_pkg::data_width-1:0]     m_wdata,
	output logic [c2c_pkg::strb_width-1:0]     m_wstrb,
	output logic                               m_wvalid,
	input  logic                               m_wready,
	input  logic                               m_bvalid,
	output logic                               m_bready
);
	import c2c_pkg::*;

	// Deframer to queue
	logic cmd_push;
	cmd_t cmd_data;
	logic cmd_full;

	// Queue to write master
	logic cmd_pop;
	logic cmd_empty;
	cmd_t cmd_head;

	//----------------------------------------
	// Link control
	//----------------------------------------
	link_ctrl i_link_ctrl (
		.aurora_clk (aurora_clk),
		.rst        (rst),
		.hard_err   (hard_err),
		.ch_up      (ch_up),
		.lane_up    (lane_up),
		.link_up    (link_up)
	);

	//----------------------------------------
	// Slave write to TX frames
	//----------------------------------------
	tx_framer i_tx_framer (
		.aurora_clk (aurora_clk),
		.rst        (rst),
		.link_up    (link_up),
		.s_awaddr   (s_awaddr),
		.s_awvalid  (s_awvalid),
		.s_awready  (s_awready),
		.s_wdata    (s_wdata),
		.s_wstrb    (s_wstrb),
		.s_wvalid   (s_wvalid),
		.s_wready   (s_wready),
		.s_bresp    (s_bresp),
		.s_bvalid   (s_bvalid),
		.s_bready   (s_bready),
		.tx_tdata   (tx_tdata),
		.tx_tlast   (tx_tlast),
		.tx_tvalid  (tx_tvalid),
		.tx_tready  (tx_tready)
	);

	//----------------------------------------
	// RX frames to master writes
	//----------------------------------------
	rx_deframer i_rx_deframer (
		.aurora_clk  (aurora_clk),
		.rst         (rst),
		.link_up     (link_up),
		.rx_tdata    (rx_tdata),
		.rx_tlast    (rx_tlast),
		.rx_tvalid   (rx_tvalid),
		.cmd_full    (cmd_full),
		.cmd_push    (cmd_push),
		.cmd_data    (cmd_data),
		.rx_overflow (rx_overflow)
	);

	cmd_fifo #(
		.depth (cmd_fifo_depth)
	) i_cmd_fifo (
		.aurora_clk (aurora_clk),
		.rst        (rst),
		.push       (cmd_push),
		.push_data  (cmd_data),
		.full       (cmd_full),
		.pop        (cmd_pop),
		.empty      (cmd_empty),
		.head       (cmd_head)
	);

	axi_write_master i_axi_write_master (
		.aurora_clk (aurora_clk),
		.rst        (rst),
		.cmd_empty  (cmd_empty),
		.cmd_head   (cmd_head),
		.cmd_pop    (cmd_pop),
		.m_awaddr   (m_awaddr),
		.m_awvalid  (m_awvalid),
		.m_awready  (m_awready),
		.m_wdata    (m_wdata),
		.m_wstrb    (m_wstrb),
		.m_wvalid   (m_wvalid),
		.m_wready   (m_wready),
		.m_bvalid   (m_bvalid),
		.m_bready   (m_bready)
	);

endmodule

// File: dv/tb_c2c_top.sv
//----------------------------------------
// Testbench for the card-to-card write bridge
// Records are read from dv/c2c_patterns.txt, so run from the project root
// Inputs change on the falling edge, outputs are sampled 1 ns before the rising edge
// Ready and bready delays are random with a fixed seed
//----------------------------------------
`timescale 1ns/100ps

module tb_c2c_top;
	import c2c_pkg::*;

	localparam int          cycles_per_record = 200;
	localparam logic [31:0] seed_init         = 32'hbbbfe1f6;

	logic                    aurora_clk;
	logic                    rst;
	logic                    hard_err;
	logic                    ch_up;
	logic [lane_count-1:0]   lane_up;
	logic                    link_up;
	logic [addr_width-1:0]   s_awaddr;
	logic                    s_awvalid;
	logic                    s_awready;
	logic [data_width-1:0]   s_wdata;
	logic [strb_width-1:0]   s_wstrb;
	logic                    s_wvalid;
	logic                    s_wready;
	logic [1:0]              s_bresp;
	logic                    s_bvalid;
	logic                    s_bready;
	logic [stream_width-1:0] tx_tdata;
	logic                    tx_tlast;
	logic                    tx_tvalid;
	logic                    tx_tready;
	logic [stream_width-1:0] rx_tdata;
	logic                    rx_tlast;
	logic                    rx_tvalid;
	logic                    rx_overflow;
	logic [addr_width-1:0]   m_awaddr;
	logic                    m_awvalid;
	logic                    m_awready;
	logic [data_width-1:0]   m_wdata;
	logic [strb_width-1:0]   m_wstrb;
	logic                    m_wvalid;
	logic                    m_wready;
	logic                    m_bvalid;
	logic                    m_bready;

	int     errors          = 0;
	int     checks          = 0;
	int     rec_count       = 0;
	int     writes_seen     = 0;
	int     writes_expected = 0;
	int     ovf_seen        = 0;
	int     ovf_expected    = 0;
	logic   loaded          = 1'b0;
	logic   hold_aw         = 1'b0;
	integer seed_tx;
	integer seed_m;

	// Expected master writes as {addr, data, strb}
	logic [67:0] exp_q[$];

	// Pattern records
	logic [63:0] kind_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [3:0]  strb_q[$];
	logic [1:0]  resp_q[$];

	c2c_top i_c2c_top (.*);

	initial begin
		aurora_clk = 1'b0;
		forever #2 aurora_clk = ~aurora_clk;
	end

	//----------------------------------------
	// Checking
	//----------------------------------------
	task automatic check(input string name, input logic [71:0] exp, input logic [71:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error: %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic load_patterns();
		int          fd;
		int          n;
		string       line;
		logic [63:0] kw;
		logic [31:0] a;
		logic [31:0] d;
		logic [3:0]  s;
		logic [1:0]  r;
		fd = $fopen("dv/c2c_patterns.txt", "r");
		if (fd == 0) begin
			report_problem("Could not open dv/c2c_patterns.txt");
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// Comment lines start with #
			if (n > 0 && line.len() > 0 && line[0] != "#") begin
				n = $sscanf(line, "%s %h %h %h %h", kw, a, d, s, r);
				if (n == 5) begin
					kind_q.push_back(kw);
					addr_q.push_back(a);
					data_q.push_back(d);
					strb_q.push_back(s);
					resp_q.push_back(r);
					rec_count++;
				end
			end
		end
		$fclose(fd);
	endtask

	//----------------------------------------
	// Link status
	//----------------------------------------
	task automatic bring_up_check();
		hard_err = 1'b0;
		ch_up    = 1'b1;
		lane_up  = '1;
		// 16 good cycles, then one more clock for the registered output
		repeat (16) @(posedge aurora_clk);
		@(negedge aurora_clk);
		check("link_up before settle time", 72'(0), 72'(link_up));
		@(negedge aurora_clk);
		check("link_up after settle time", 72'(1), 72'(link_up));
	endtask

	task automatic ensure_link_up();
		if (link_up !== 1'b1)
			bring_up_check();
	endtask

	// hard_err stays high until the link is needed again
	task automatic drop_link(input string name);
		hard_err = 1'b1;
		@(negedge aurora_clk);
		check({name, " link_up after hard_err"}, 72'(0), 72'(link_up));
	endtask

	//----------------------------------------
	// Slave write and TX stream
	//----------------------------------------
	task automatic slave_write(input string name, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] strb, input logic [1:0] resp);
		int   beats;
		logic got;
		logic done;
		s_awaddr  = addr;
		s_wdata   = data;
		s_wstrb   = strb;
		s_awvalid = 1'b1;
		s_wvalid  = 1'b1;
		got = 1'b0;
		while (!got) begin
			#1;
			got = s_awready && s_wready;
			@(negedge aurora_clk);
		end
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		beats = 0;
		done  = 1'b0;
		while (!done) begin
			tx_tready = ({$random(seed_tx)} % 4) != 0;
			s_bready  = ({$random(seed_tx)} % 2) != 0;
			#1;
			if (tx_tvalid && resp != 2'b00) begin
				report_problem({name, ": TX beat sent for a write taken while the link was down"});
			end else if (tx_tvalid && tx_tready) begin
				if (beats == 0)
					check({name, " tx header"}, 72'({1'b0, 8'h57, 24'h0, addr}),
						72'({tx_tlast, tx_tdata}));
				else
					check({name, " tx data"}, 72'({1'b1, 28'h0, strb, data}),
						72'({tx_tlast, tx_tdata}));
				beats++;
			end
			if (s_bvalid && s_bready) begin
				check({name, " s_bresp"}, 72'(resp), 72'(s_bresp));
				check({name, " tx beat count"}, 72'((resp == 2'b00) ? 2 : 0), 72'(beats));
				done = 1'b1;
			end
			@(negedge aurora_clk);
		end
		tx_tready = 1'b0;
		s_bready  = 1'b0;
	endtask

	//----------------------------------------
	// RX stream
	//----------------------------------------
	task automatic rx_frame(input string name, input logic [7:0] op, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] strb, input logic two_beats,
		input logic drop_exp);
		rx_tvalid = 1'b1;
		rx_tdata  = {op, 24'h0, addr};
		rx_tlast  = !two_beats;
		@(negedge aurora_clk);
		if (two_beats) begin
			rx_tdata = {28'h0, strb, data};
			rx_tlast = 1'b1;
			@(negedge aurora_clk);
		end
		rx_tvalid = 1'b0;
		rx_tlast  = 1'b0;
		rx_tdata  = '0;
		// Overflow pulse follows the tlast beat by one clock
		check({name, " rx_overflow"}, 72'(drop_exp), 72'(rx_overflow));
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0 || m_awvalid || m_wvalid || m_bready)
			@(negedge aurora_clk);
	endtask

	task automatic run_record(input int i);
		logic [63:0] kw;
		string       name;
		kw   = kind_q[i];
		name = $sformatf("record %0d", i);
		if (!(kw == 64'("rxw") && resp_q[i] != 2'd0))
			hold_aw = 1'b0;
		if (kw == 64'("drop")) begin
			ensure_link_up();
			drop_link(name);
		end else if (kw == 64'("sw")) begin
			if (resp_q[i] == 2'b00)
				ensure_link_up();
			slave_write(name, addr_q[i], data_q[i], strb_q[i], resp_q[i]);
		end else if (kw == 64'("rxw")) begin
			ensure_link_up();
			// Start of an overflow run, master must be idle first
			if (resp_q[i] != 2'd0 && !hold_aw) begin
				wait_drained();
				hold_aw = 1'b1;
			end
			if (resp_q[i] != 2'd2) begin
				exp_q.push_back({addr_q[i], data_q[i], strb_q[i]});
				writes_expected++;
			end else begin
				ovf_expected++;
			end
			rx_frame(name, 8'h57, addr_q[i], data_q[i], strb_q[i], 1'b1, resp_q[i] == 2'd2);
		end else if (kw == 64'("nop")) begin
			ensure_link_up();
			rx_frame(name, 8'h4e, addr_q[i], 32'h0, 4'h0, 1'b0, 1'b0);
		end else if (kw == 64'("unk")) begin
			ensure_link_up();
			rx_frame(name, 8'hc3, addr_q[i], data_q[i], strb_q[i], 1'b1, 1'b0);
		end else begin
			report_problem({name, ": unknown record kind in the pattern file"});
		end
	endtask

	//----------------------------------------
	// Master side responder
	//----------------------------------------
	initial begin : master_side
		logic [31:0] got_addr;
		logic [31:0] got_data;
		logic [3:0]  got_strb;
		logic        aw_seen;
		logic        w_seen;
		logic [67:0] exp;
		m_awready = 1'b0;
		m_wready  = 1'b0;
		m_bvalid  = 1'b0;
		aw_seen   = 1'b0;
		w_seen    = 1'b0;
		seed_m    = seed_init;
		forever begin
			@(negedge aurora_clk);
			m_awready = !hold_aw && (({$random(seed_m)} % 3) != 0);
			m_wready  = ({$random(seed_m)} % 3) != 0;
			m_bvalid  = m_bready && (({$random(seed_m)} % 2) != 0);
			#1;
			if (m_awvalid && m_awready) begin
				got_addr = m_awaddr;
				aw_seen  = 1'b1;
			end
			if (m_wvalid && m_wready) begin
				got_data = m_wdata;
				got_strb = m_wstrb;
				w_seen   = 1'b1;
			end
			if (aw_seen && w_seen) begin
				aw_seen = 1'b0;
				w_seen  = 1'b0;
				writes_seen++;
				if (exp_q.size() == 0) begin
					report_problem("Master write issued with no RX write frame pending");
				end else begin
					exp = exp_q.pop_front();
					check($sformatf("master write %0d", writes_seen), 72'(exp),
						72'({got_addr, got_data, got_strb}));
				end
			end
		end
	end

	always @(negedge aurora_clk)
		if (rx_overflow === 1'b1)
			ovf_seen++;

	initial begin : watchdog
		wait (loaded);
		repeat ((rec_count + 2) * cycles_per_record) @(posedge aurora_clk);
		$display("Timeout: the run did not finish within %0d cycles",
			(rec_count + 2) * cycles_per_record);
		$display("Checks: %0d  errors: %0d", checks, errors);
		$display("Testbench failed");
		$finish;
	end

	//----------------------------------------
	// Main sequence
	//----------------------------------------
	initial begin : main
		rst       = 1'b1;
		hard_err  = 1'b0;
		ch_up     = 1'b0;
		lane_up   = '0;
		s_awaddr  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wstrb   = '0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b0;
		tx_tready = 1'b0;
		rx_tdata  = '0;
		rx_tlast  = 1'b0;
		rx_tvalid = 1'b0;
		seed_tx   = seed_init;
		load_patterns();
		loaded = 1'b1;
		repeat (3) @(posedge aurora_clk);
		@(negedge aurora_clk);
		rst = 1'b0;
		check("link_up after reset", 72'(0), 72'(link_up));
		if (rec_count == 0)
			report_problem("No pattern records were read");
		for (int i = 0; i < rec_count; i++)
			run_record(i);
		hold_aw = 1'b0;
		wait_drained();
		repeat (20) @(negedge aurora_clk);
		check("master write count", 72'(writes_expected), 72'(writes_seen));
		check("rx_overflow pulse count", 72'(ovf_expected), 72'(ovf_seen));
		$display("Checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: dv/c2c_patterns.txt
# kind addr data strb resp, all hex, one record per line
# sw resp is the expected s_bresp; rxw resp 0 queued, 1 master held, 2 held and dropped
sw   00001000 11223344 f 0
sw   00001004 a5a5a5a5 3 0
sw   8000fffc 0badf00d 8 0
drop 00000000 00000000 0 0
sw   00002000 deadbeef f 2
rxw  40000000 cafe0001 f 0
rxw  40000004 cafe0002 1 0
rxw  40000008 cafe0003 6 0
nop  12345678 00000000 0 0
unk  9abcdef0 55aa55aa f 0
rxw  4000000c cafe0004 c 0
rxw  50000000 00000001 f 1
rxw  50000004 00000002 e 1
rxw  50000008 00000003 d 1
rxw  5000000c 00000004 b 1
rxw  50000010 00000005 7 1
rxw  50000014 00000006 f 2
sw   00003000 13579bdf f 0
rxw  60000000 2468ace0 5 0

// File: src.f
verilog/c2c_pkg.sv
verilog/link_ctrl.sv
verilog/tx_framer.sv
verilog/rx_deframer.sv
verilog/cmd_fifo.sv
verilog/axi_write_master.sv
verilog/c2c_top.sv
dv/tb_c2c_top.sv

// File: Makefile
# Verilator build, run and lint for the card-to-card write bridge
# Run from the project root, the testbench reads dv/c2c_patterns.txt

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_c2c_top
RTL_TOP   ?= c2c_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timescale 1ns/100ps
SIM       := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
